// File: logic/oct_cal_fsm.sv
/* Calibration request FSM: accepts a user level request, drives one
   calibration cycle of the OCT engine and reports ready back to the user */

`timescale 1ns/10ps
`default_nettype none

module oct_cal_fsm
   import oct_pkg::*;
(
   input  logic w_oct_clock,
   input  logic w_oct_reset,
   input  logic cal_req_sync,
   input  logic engine_busy_sync,
   output logic cal_rdy,
   output logic engine_cal_request
);

   oct_state_t state_q;
   oct_state_t state_d;
   logic       rdy_q;
   logic       rdy_d;
   logic       req_q;
   logic       req_d;

   // State and both outputs are registered together
   always_ff @(posedge w_oct_clock)
   begin
      if (w_oct_reset)
      begin
         state_q <= st_reset;
         rdy_q   <= 1'b0;
         req_q   <= 1'b0;
      end
      else
      begin
         state_q <= state_d;
         rdy_q   <= rdy_d;
         req_q   <= req_d;
      end
   end

   always_comb
   begin
      state_d = st_reset;
      rdy_d   = 1'b0;
      req_d   = 1'b0;

      case (state_q)
         st_reset:
         begin
            state_d = st_wait_idle;
         end

         // Hold off the user until the engine is quiet
         st_wait_idle:
         begin
            state_d = engine_busy_sync ? st_wait_idle : st_wait_req_hi;
            rdy_d   = !engine_busy_sync;
         end

         // Ready stays up until the request shows up
         st_wait_req_hi:
         begin
            state_d = cal_req_sync ? st_wait_busy_hi : st_wait_req_hi;
            rdy_d   = !cal_req_sync;
         end

         // The request to the engine is held until busy is seen, so a slow
         // engine cannot miss it
         st_wait_busy_hi:
         begin
            state_d = engine_busy_sync ? st_wait_busy_lo : st_wait_busy_hi;
            req_d   = 1'b1;
         end

         st_wait_busy_lo:
         begin
            state_d = engine_busy_sync ? st_wait_busy_lo : st_wait_req_lo;
         end

         // The user must drop the request before a new one can be taken
         st_wait_req_lo:
         begin
            state_d = cal_req_sync ? st_wait_req_lo : st_done;
         end

         st_done:
         begin
            state_d = st_reset;
         end

         default:
         begin
            state_d = st_reset;
         end
      endcase
   end

   assign cal_rdy            = rdy_q;
   assign engine_cal_request = req_q;

endmodule : oct_cal_fsm

`default_nettype wire

// File: logic/oct_ctrl_top.sv
/* OCT calibration controller top level: input synchronizers, calibration
   request FSM and periodic recalibration timer */

`timescale 1ns/10ps
`default_nettype none

module oct_ctrl_top
   import oct_pkg::*;
#(
   parameter int                         SYNC_STAGES  = OCT_SYNC_STAGES_DEFAULT,
   // Default gives 500 ms between toggles at a 100 MHz clock
   parameter logic [OCT_TIMER_WIDTH-2:0] RECAL_PRESET = 31'd49_999_998
)
(
   input  logic w_oct_clock,
   input  logic w_oct_reset,

   // User side
   input  logic cal_req,
   output logic cal_rdy,
   output logic recal_req,
   input  logic s2pload_ena,
   output logic s2pload_rdy,

   // Calibration engine side
   input  logic engine_busy,
   input  logic engine_s2pload_rdy,
   output logic engine_cal_request,
   output logic engine_s2pload_ena
);

   logic cal_req_sync;
   logic engine_busy_sync;

   oct_input_sync #(
      .SYNC_STAGES(SYNC_STAGES)
   ) i_input_sync (
      .w_oct_clock       (w_oct_clock),
      .w_oct_reset       (w_oct_reset),
      .cal_req           (cal_req),
      .engine_busy       (engine_busy),
      .s2pload_ena       (s2pload_ena),
      .engine_s2pload_rdy(engine_s2pload_rdy),
      .cal_req_sync      (cal_req_sync),
      .engine_busy_sync  (engine_busy_sync),
      .s2pload_ena_sync  (engine_s2pload_ena),
      .s2pload_rdy_sync  (s2pload_rdy)
   );

   oct_cal_fsm i_cal_fsm (
      .w_oct_clock       (w_oct_clock),
      .w_oct_reset       (w_oct_reset),
      .cal_req_sync      (cal_req_sync),
      .engine_busy_sync  (engine_busy_sync),
      .cal_rdy           (cal_rdy),
      .engine_cal_request(engine_cal_request)
   );

   // Periodic recalibration is always present
   oct_recal_timer #(
      .RECAL_PRESET(RECAL_PRESET)
   ) i_recal_timer (
      .w_oct_clock(w_oct_clock),
      .w_oct_reset(w_oct_reset),
      .recal_req  (recal_req)
   );

endmodule : oct_ctrl_top

`default_nettype wire

// File: logic/oct_input_sync.sv
/* Synchronizer bank for the asynchronous inputs of the OCT controller */

`timescale 1ns/10ps
`default_nettype none

module oct_input_sync
   import oct_pkg::*;
#(
   parameter int SYNC_STAGES = OCT_SYNC_STAGES_DEFAULT
)
(
   input  logic w_oct_clock,
   input  logic w_oct_reset,
   input  logic cal_req,
   input  logic engine_busy,
   input  logic s2pload_ena,
   input  logic engine_s2pload_rdy,
   output logic cal_req_sync,
   output logic engine_busy_sync,
   output logic s2pload_ena_sync,
   output logic s2pload_rdy_sync
);

   // Lane of each input within the bank
   localparam int CAL_REQ_BIT  = 0;
   localparam int BUSY_BIT     = 1;
   localparam int LOAD_ENA_BIT = 2;
   localparam int LOAD_RDY_BIT = 3;
   localparam int NUM_INPUTS   = 4;

   // One word per stage, one bit per input
   // Stage 0 is the metastable flop, the last stage feeds the outputs
   (* preserve, async_reg = "true" *)
   logic [NUM_INPUTS-1:0] sync_q [SYNC_STAGES];

   always_ff @(posedge w_oct_clock)
   begin
      if (w_oct_reset)
      begin
         for (int i = 0; i < SYNC_STAGES; i++)
         begin
            sync_q[i] <= '0;
         end
      end
      else
      begin
         sync_q[0] <= {engine_s2pload_rdy, s2pload_ena, engine_busy, cal_req};
         for (int i = 1; i < SYNC_STAGES; i++)
         begin
            sync_q[i] <= sync_q[i-1];
         end
      end
   end

   assign cal_req_sync     = sync_q[SYNC_STAGES-1][CAL_REQ_BIT];
   assign engine_busy_sync = sync_q[SYNC_STAGES-1][BUSY_BIT];
   assign s2pload_ena_sync = sync_q[SYNC_STAGES-1][LOAD_ENA_BIT];
   assign s2pload_rdy_sync = sync_q[SYNC_STAGES-1][LOAD_RDY_BIT];

endmodule : oct_input_sync

`default_nettype wire

// File: logic/oct_pkg.sv
/* Shared definitions of the OCT calibration controller: the calibration
   state type, the recalibration counter width and the synchronizer depth */

`default_nettype none

package oct_pkg;

   // Calibration state machine states, in the order one calibration walks them
   typedef enum logic [2:0]
   {
      st_reset,
      st_wait_idle,
      st_wait_req_hi,
      st_wait_busy_hi,
      st_wait_busy_lo,
      st_wait_req_lo,
      st_done
   } oct_state_t;

   // Width of the recalibration down-counter
   // The top bit is the expiry flag, the lower bits hold the preset
   parameter int OCT_TIMER_WIDTH = 32;

   // Default number of flops in each input synchronizer
   parameter int OCT_SYNC_STAGES_DEFAULT = 3;

endpackage : oct_pkg

`default_nettype wire

// File: logic/oct_recal_timer.sv
/* Periodic recalibration timer that toggles the recalibration request level */

`timescale 1ns/10ps
`default_nettype none

module oct_recal_timer
   import oct_pkg::*;
#(
   parameter logic [OCT_TIMER_WIDTH-2:0] RECAL_PRESET = 31'd49_999_998
)
(
   input  logic w_oct_clock,
   input  logic w_oct_reset,
   output logic recal_req
);

   logic [OCT_TIMER_WIDTH-1:0] count_q;
   logic                       expired;
   logic                       recal_req_q;

   // The counter underflows past zero into the top bit
   assign expired = count_q[OCT_TIMER_WIDTH-1];

   always_ff @(posedge w_oct_clock)
   begin
      if (w_oct_reset)
      begin
         count_q     <= {1'b0, RECAL_PRESET};
         recal_req_q <= 1'b0;
      end
      else if (expired)
      begin
         // Reload one cycle after expiry, so a period is RECAL_PRESET + 2
         count_q     <= {1'b0, RECAL_PRESET};
         recal_req_q <= !recal_req_q;
      end
      else
      begin
         count_q <= count_q - 1'b1;
      end
   end

   // A level toggle rather than a pulse, so a slow user side still sees it
   assign recal_req = recal_req_q;

endmodule : oct_recal_timer

`default_nettype wire

// File: src.f
logic/oct_pkg.sv
logic/oct_input_sync.sv
logic/oct_cal_fsm.sv
logic/oct_recal_timer.sv
logic/oct_ctrl_top.sv
verif/oct_ctrl_properties.sv
verif/oct_ctrl_tb.sv

// File: verif/oct_ctrl_properties.sv
/* Concurrent assertions on the calibration request FSM, bound into oct_cal_fsm */

`timescale 1ns/10ps
`default_nettype none

module oct_ctrl_properties
   import oct_pkg::*;
(
   input  logic       w_oct_clock,
   input  logic       w_oct_reset,
   input  logic       cal_req_sync,
   input  logic       cal_rdy,
   input  logic       engine_cal_request,
   input  oct_state_t state_q
);

   // The user is never told ready while the engine is being asked
   rdy_req_exclusive: assert property (
      @(posedge w_oct_clock) disable iff (w_oct_reset)
      !(cal_rdy && engine_cal_request)
   ) else $error("cal_rdy and engine_cal_request high together");

   // Once busy is seen the request is still up for the first cycle of st_wait_busy_lo
   req_only_near_busy_hi: assert property (
      @(posedge w_oct_clock) disable iff (w_oct_reset)
      engine_cal_request |-> (state_q == st_wait_busy_hi ||
                              (state_q == st_wait_busy_lo &&
                               $rose(state_q == st_wait_busy_lo)))
   ) else $error("engine_cal_request high outside st_wait_busy_hi");

   // Ready only drops in answer to a synchronized user request
   rdy_falls_on_req: assert property (
      @(posedge w_oct_clock) disable iff (w_oct_reset)
      $fell(cal_rdy) |-> $past(cal_req_sync)
   ) else $error("cal_rdy fell without a synchronized request");

endmodule : oct_ctrl_properties

bind oct_cal_fsm oct_ctrl_properties i_properties (
   .w_oct_clock       (w_oct_clock),
   .w_oct_reset       (w_oct_reset),
   .cal_req_sync      (cal_req_sync),
   .cal_rdy           (cal_rdy),
   .engine_cal_request(engine_cal_request),
   .state_q           (state_q)
);

`default_nettype wire

// File: verif/oct_ctrl_tb.sv
/* Testbench for the OCT calibration controller: clock, reset, xorshift stimulus,
   calibration engine model, reference model and checks */

`timescale 1ns/10ps
`default_nettype none

module oct_ctrl_tb
   import oct_pkg::*;
();

   localparam int PRESET     = 300;
   localparam int PERIOD     = PRESET + 2;
   localparam int RUN_CYCLES = 20000;

   logic w_oct_clock;
   logic w_oct_reset;
   logic cal_req;
   logic cal_rdy;
   logic recal_req;
   logic s2pload_ena;
   logic s2pload_rdy;
   logic engine_busy;
   logic engine_s2pload_rdy;
   logic engine_cal_request;
   logic engine_s2pload_ena;

   logic [31:0] rng_state = 32'hd3374b93;
   int          errors = 0;
   int          start_errors = 0;
   int          tests_run = 0;
   int          cycle;
   int          user_req_count = 0;
   int          engine_cal_count = 0;
   int          busy_rises = 0;
   int          rises_with_req = 0;
   logic        long_busy = 1'b0;
   logic        busy_prev = 1'b0;
   logic        recal_prev = 1'b0;
   int          recal_times[$];

   oct_ctrl_top #(
      .SYNC_STAGES (3),
      .RECAL_PRESET(PRESET)
   ) i_dut (
      .w_oct_clock       (w_oct_clock),
      .w_oct_reset       (w_oct_reset),
      .cal_req           (cal_req),
      .cal_rdy           (cal_rdy),
      .recal_req         (recal_req),
      .s2pload_ena       (s2pload_ena),
      .s2pload_rdy       (s2pload_rdy),
      .engine_busy       (engine_busy),
      .engine_s2pload_rdy(engine_s2pload_rdy),
      .engine_cal_request(engine_cal_request),
      .engine_s2pload_ena(engine_s2pload_ena)
   );

   initial
   begin
      w_oct_clock = 1'b0;
      forever
      begin
         #4 w_oct_clock = !w_oct_clock;
      end
   end

   function automatic logic [31:0] next_random();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   function automatic int random_range(input int lo, input int hi);
      return lo + int'(next_random() % $unsigned(hi - lo + 1));
   endfunction

   task automatic report_mismatch(input string test, input string what,
                                  input int expected, input int actual);
      $display("[FAIL] %s: %s expected %0d, actual %0d", test, what, expected, actual);
      errors++;
   endtask

   task automatic report_problem(input string test, input string what);
      $display("[FAIL] %s: %s", test, what);
      errors++;
   endtask

   task automatic close_test(input string test);
      tests_run++;
      $display("Test %s finished with %0d errors", test, errors - start_errors);
   endtask

   task automatic wait_cal_rdy(input string test, input logic level, input int limit);
      int n;
      n = 0;
      while (cal_rdy !== level && n < limit)
      begin
         @(negedge w_oct_clock);
         n++;
      end
      if (cal_rdy !== level)
      begin
         report_problem(test, $sformatf("cal_rdy did not reach %0b within %0d cycles",
                                        level, limit));
      end
   endtask

   task automatic wait_engine_count(input string test, input int target, input int limit);
      int n;
      n = 0;
      while (engine_cal_count < target && n < limit)
      begin
         @(negedge w_oct_clock);
         n++;
      end
      if (engine_cal_count < target)
      begin
         report_problem(test, "engine model did not finish its calibration in time");
      end
   endtask

   // Model of the calibration engine, answering each request with one busy pulse
   initial
   begin : engine_model
      int delay;
      int len;
      int n;
      forever
      begin
         @(negedge w_oct_clock);
         if (!w_oct_reset && engine_cal_request)
         begin
            delay = random_range(0, 5);
            repeat (delay) @(negedge w_oct_clock);
            engine_busy = 1'b1;
            len = long_busy ? random_range(100, 300) : random_range(2, 20);
            repeat (len) @(negedge w_oct_clock);
            engine_busy = 1'b0;
            engine_cal_count++;
            // A short busy pulse can end while the request is still up
            n = 0;
            while (engine_cal_request && n < 20)
            begin
               @(negedge w_oct_clock);
               n++;
            end
            if (engine_cal_request)
            begin
               report_problem("engine", "engine_cal_request stayed high after busy fell");
            end
         end
      end
   end

   always @(posedge w_oct_clock)
   begin
      if (w_oct_reset)
      begin
         cycle <= 0;
      end
      else
      begin
         cycle <= cycle + 1;
      end
   end

   // The DUT must still hold its request when busy rises
   always @(posedge w_oct_clock)
   begin
      if (engine_busy && !busy_prev)
      begin
         busy_rises++;
         if (engine_cal_request)
         begin
            rises_with_req++;
         end
      end
      busy_prev = engine_busy;
   end

   always @(negedge w_oct_clock)
   begin
      if (w_oct_reset)
      begin
         recal_prev = 1'b0;
      end
      else
      begin
         if (recal_req !== recal_prev)
         begin
            recal_times.push_back(cycle);
         end
         recal_prev = recal_req;
      end
   end

   task automatic check_reset_state();
      string name;
      name = "reset";
      start_errors = errors;
      for (int i = 0; i < 9; i++)
      begin
         @(negedge w_oct_clock);
         // The ninth sample is the first cycle after release
         if (cal_rdy !== 1'b0 || engine_cal_request !== 1'b0 || recal_req !== 1'b0)
         begin
            report_problem(name, $sformatf("outputs not low in cycle %0d of reset", i));
         end
         if (i == 7)
         begin
            w_oct_reset = 1'b0;
         end
      end
      wait_cal_rdy(name, 1'b1, 20);
      close_test(name);
   endtask

   task automatic do_calibration(input string test);
      wait_cal_rdy(test, 1'b1, 50);
      cal_req = 1'b1;
      wait_cal_rdy(test, 1'b0, 20);
      user_req_count++;
      wait_engine_count(test, user_req_count, 100);
      cal_req = 1'b0;
      wait_cal_rdy(test, 1'b1, 50);
      if (engine_cal_count != user_req_count)
      begin
         report_mismatch(test, "engine calibrations", user_req_count, engine_cal_count);
      end
      if (rises_with_req != busy_rises)
      begin
         report_mismatch(test, "busy rises with the request high", busy_rises,
                         rises_with_req);
      end
   endtask

   task automatic run_handshakes();
      string name;
      int    gap;
      name = "handshake";
      start_errors = errors;
      for (int i = 0; i < 30; i++)
      begin
         gap = random_range(0, 7);
         repeat (gap) @(negedge w_oct_clock);
         do_calibration(name);
      end
      close_test(name);
   endtask

   task automatic run_back_pressure();
      string name;
      int    n;
      logic  rdy_seen;
      name = "back_pressure";
      start_errors = errors;
      rdy_seen = 1'b0;
      long_busy = 1'b1;
      wait_cal_rdy(name, 1'b1, 50);
      cal_req = 1'b1;
      wait_cal_rdy(name, 1'b0, 20);
      user_req_count++;
      n = 0;
      while (!engine_busy && n < 50)
      begin
         @(negedge w_oct_clock);
         n++;
      end
      n = 0;
      while (engine_busy && n < 400)
      begin
         if (cal_rdy)
         begin
            rdy_seen = 1'b1;
         end
         @(negedge w_oct_clock);
         n++;
      end
      if (rdy_seen)
      begin
         report_problem(name, "cal_rdy went high while the engine was busy");
      end
      wait_engine_count(name, user_req_count, 400);
      cal_req = 1'b0;
      wait_cal_rdy(name, 1'b1, 50);
      if (engine_cal_count != user_req_count)
      begin
         report_mismatch(name, "engine calibrations", user_req_count, engine_cal_count);
      end
      long_busy = 1'b0;
      close_test(name);
   endtask

   task automatic check_recal_timer();
      string name;
      int    n;
      name = "recal_timer";
      start_errors = errors;
      n = 0;
      while (recal_times.size() < 3 && n < 4 * PERIOD)
      begin
         @(negedge w_oct_clock);
         n++;
      end
      if (recal_times.size() < 3)
      begin
         report_problem(name, "recal_req toggled fewer than three times");
      end
      else
      begin
         for (int k = 0; k < 3; k++)
         begin
            if (recal_times[k] != (k + 1) * PERIOD)
            begin
               report_mismatch(name, "toggle cycle", (k + 1) * PERIOD, recal_times[k]);
            end
         end
      end
      close_test(name);
   endtask

   task automatic toggle_load_signals();
      string       name;
      logic [31:0] r;
      logic        value;
      logic        seen;
      int          n;
      name = "load";
      start_errors = errors;
      for (int i = 0; i < 20; i++)
      begin
         r = next_random();
         if (r[0])
         begin
            value = !s2pload_ena;
            s2pload_ena = value;
         end
         else
         begin
            value = !engine_s2pload_rdy;
            engine_s2pload_rdy = value;
         end
         n = 0;
         seen = r[0] ? engine_s2pload_ena : s2pload_rdy;
         while (seen !== value && n < 10)
         begin
            @(negedge w_oct_clock);
            n++;
            seen = r[0] ? engine_s2pload_ena : s2pload_rdy;
         end
         if (seen !== value)
         begin
            report_mismatch(name, r[0] ? "engine_s2pload_ena" : "s2pload_rdy", value, seen);
         end
         repeat (random_range(5, 10)) @(negedge w_oct_clock);
      end
      close_test(name);
   endtask

   initial
   begin
      w_oct_reset = 1'b1;
      cal_req = 1'b0;
      s2pload_ena = 1'b0;
      engine_busy = 1'b0;
      engine_s2pload_rdy = 1'b0;
      check_reset_state();
      run_handshakes();
      run_back_pressure();
      check_recal_timer();
      toggle_load_signals();
      $display("Tests run: %0d, errors: %0d", tests_run, errors);
      if (errors == 0)
      begin
         $display("Everything OK");
      end
      else
      begin
         $display("Something failed");
      end
      $finish;
   end

   // Stops a run that hangs in spite of the local timeouts
   initial
   begin
      repeat (RUN_CYCLES) @(posedge w_oct_clock);
      $display("Simulation did not finish within %0d cycles", RUN_CYCLES);
      $display("Something failed");
      $finish;
   end

endmodule : oct_ctrl_tb

`default_nettype wire
